/* common/smu_pkg.sv */
`default_nettype none

// shared widths, thresholds and state encodings of the stack management unit
package smu_pkg;

	// the entry count from the data path is a 30 bit value
	// its sign travels separately on und_flw_bit
	localparam int unsigned NUM_ENTRIES_W = 30;

	// low and high watermarks are programmed through the PSR and are 6 bits wide
	localparam int unsigned MARK_W = 6;

	// below six entries the integer unit has to wait for fills to land
	localparam logic [MARK_W-1:0] SIX_LIMIT = 6'd6;

	// more than 59 entries is an overflow
	// this keeps at least four free locations in the 64 entry stack cache
	localparam logic [MARK_W-1:0] OVR_FLW_LIMIT = 6'd59;

	// one-hot dribbler states
	// the overflow pair flushes dirty entries out to the data cache
	// the underflow pair reloads the stack bottom from optop and refills
	typedef enum logic [4:0] {
		IDLE       = 5'b00001,
		STALL_OVR1 = 5'b00010,
		STALL_OVR2 = 5'b00100,
		STALL_UND1 = 5'b01000,
		STALL_UND2 = 5'b10000
	} dribb_state_e;

	// one-hot six-entry guard states
	// the guard keeps the integer unit held while fewer than six entries are valid
	typedef enum logic [1:0] {
		SIX_IDLE  = 2'b01,
		STALL_SIX = 2'b10
	} six_state_e;

endpackage

`default_nettype wire

/* watermark/stack_level_cmp.sv */
`default_nettype none
`timescale 1ns/100ps

// watermark and threshold comparisons on the signed stack cache entry count
// purely combinational, all results land in the same cycle as the count
module stack_level_cmp (
	input  wire logic [smu_pkg::NUM_ENTRIES_W-1:0] num_entries,
	input  wire logic                             und_flw_bit,
	input  wire logic                             iu_psr_dre,
	input  wire logic [smu_pkg::MARK_W-1:0]       low_mark,
	input  wire logic [smu_pkg::MARK_W-1:0]       high_mark,
	output logic                                  spill_d,
	output logic                                  fill_d,
	output logic                                  ovr_flw_d,
	output logic                                  und_flw_d,
	output logic                                  less_than_6
);

	// the count splits into the bits a 6 bit mark can reach and the rest
	logic                       upper_nz;
	logic [smu_pkg::MARK_W-1:0] low_bits;

	// raw compare results before the dribble enable
	logic spill_raw;
	logic fill_raw;
	logic ovr_raw;
	logic six_raw;

	assign upper_nz = |num_entries[smu_pkg::NUM_ENTRIES_W-1:smu_pkg::MARK_W];
	assign low_bits = num_entries[smu_pkg::MARK_W-1:0];

	// a positive count is above a mark if any upper bit is set, otherwise
	// the low bits decide
	assign spill_raw = !und_flw_bit && (upper_nz || (low_bits > high_mark));
	assign ovr_raw   = !und_flw_bit && (upper_nz || (low_bits > smu_pkg::OVR_FLW_LIMIT));

	// a negative count is below every mark
	// a positive one is below only if the upper bits are all clear
	assign fill_raw = und_flw_bit || (!upper_nz && (low_bits < low_mark));
	assign six_raw  = und_flw_bit || (!upper_nz && (low_bits < smu_pkg::SIX_LIMIT));

	// with the dribbler switched off nothing is reported at all, so no fills,
	// spills or stalls are raised whatever the count says
	always_comb begin
		spill_d     = spill_raw   & iu_psr_dre;
		fill_d      = fill_raw    & iu_psr_dre;
		ovr_flw_d   = ovr_raw     & iu_psr_dre;
		und_flw_d   = und_flw_bit & iu_psr_dre;
		less_than_6 = six_raw     & iu_psr_dre;
	end

endmodule

`default_nettype wire

/* dribbler/dribble_fsm.sv */
`default_nettype none
`timescale 1ns/100ps

// dribbler and six-entry guard state machines
// raises dribble_stall to the integer unit while an overflow or underflow is
// being recovered, and produces the squash controls for the request pipeline
module dribble_fsm (
	input  wire logic clk,
	input  wire logic arst_n,
	input  wire logic spill_d,
	input  wire logic ovr_flw_d,
	input  wire logic und_flw_d,
	input  wire logic less_than_6,
	input  wire logic spill,
	input  wire logic zero_entries_fl,
	input  wire logic iu_int,
	output logic      dribble_stall,
	output logic      optop_en,
	output logic      squash_fill,
	output logic      squash_hold,
	output logic      flush_pipe
);

	smu_pkg::dribb_state_e dribb_state;
	smu_pkg::dribb_state_e nxt_dribb_state;
	smu_pkg::six_state_e   six_state;
	smu_pkg::six_state_e   nxt_six_state;

	// state decodes
	logic idle;
	logic stall_ovr2;
	logic stall_ovr_flw;
	logic stall_und_flw;
	logic idle_six;
	logic stall_six;

	// a spill whose address equals the old optop means every dirty entry is out
	logic zero_entries;
	logic zero_entries_c;
	logic squash_state;
	logic squash_hold_c;
	logic squash_hold_w;

	assign idle          = (dribb_state == smu_pkg::IDLE);
	assign stall_ovr2    = (dribb_state == smu_pkg::STALL_OVR2);
	assign stall_ovr_flw = (dribb_state == smu_pkg::STALL_OVR1) || stall_ovr2;
	assign stall_und_flw = (dribb_state == smu_pkg::STALL_UND1) ||
	                       (dribb_state == smu_pkg::STALL_UND2);
	assign idle_six      = (six_state == smu_pkg::SIX_IDLE);
	assign stall_six     = (six_state == smu_pkg::STALL_SIX);

	assign zero_entries = zero_entries_fl & spill;

	// once the overflow flush reaches the old optop the stack is empty, and
	// recovery carries on like an underflow
	assign squash_state = zero_entries & stall_ovr2;

	// kill requests already decoded when recovery starts
	assign flush_pipe = (idle & (und_flw_d | ovr_flw_d)) | squash_state;

	// the stall includes the raw conditions so a push in the detect cycle
	// cannot move optop past a datum that was never saved
	assign dribble_stall = stall_ovr_flw | stall_und_flw | ovr_flw_d | und_flw_d |
	                       (idle_six & less_than_6 & !und_flw_d) | stall_six;

	// optop is frozen through the overflow so its old value marks the flush end
	assign optop_en = !(stall_ovr_flw | ovr_flw_d);

	// squash_hold lets the cache-stage stack bottom follow through a DCU stall
	// for the two cycles around the start of recovery
	assign squash_hold = squash_hold_c | squash_hold_w;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			squash_fill    <= 1'b0;
			squash_hold_c  <= 1'b0;
			squash_hold_w  <= 1'b0;
			zero_entries_c <= 1'b0;
		end else begin
			// every underflow is a return underflow, so the stack bottom is
			// reloaded from optop one clock after it is seen in idle
			squash_fill    <= (und_flw_d & idle) | squash_state;
			squash_hold_c  <= (ovr_flw_d | und_flw_d) & idle;
			squash_hold_w  <= squash_fill;
			zero_entries_c <= zero_entries;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dribb_state <= smu_pkg::IDLE;
			six_state   <= smu_pkg::SIX_IDLE;
		end else begin
			dribb_state <= nxt_dribb_state;
			six_state   <= nxt_six_state;
		end
	end

	// dribbler next state
	always_comb begin
		nxt_dribb_state = dribb_state;
		case (dribb_state)
			smu_pkg::IDLE: begin
				if (und_flw_d) begin
					nxt_dribb_state = smu_pkg::STALL_UND1;
				end else if (ovr_flw_d) begin
					nxt_dribb_state = smu_pkg::STALL_OVR1;
				end
			end
			smu_pkg::STALL_UND1: begin
				nxt_dribb_state = iu_int ? smu_pkg::IDLE : smu_pkg::STALL_UND2;
			end
			// wait for the refill to bring the stack back to six entries
			smu_pkg::STALL_UND2: begin
				if (!less_than_6 || iu_int) begin
					nxt_dribb_state = smu_pkg::IDLE;
				end
			end
			smu_pkg::STALL_OVR1: begin
				nxt_dribb_state = iu_int ? smu_pkg::IDLE : smu_pkg::STALL_OVR2;
			end
			smu_pkg::STALL_OVR2: begin
				if (iu_int) begin
					nxt_dribb_state = smu_pkg::IDLE;
				end else if (zero_entries_c) begin
					nxt_dribb_state = smu_pkg::STALL_UND2;
				end else if (zero_entries && !spill_d) begin
					// spill_d may drop in the very cycle the flush hits the old
					// optop, and going idle here would release the hold for one
					// cycle before the empty stack stalls again
					nxt_dribb_state = smu_pkg::STALL_UND1;
				end else if (!spill_d) begin
					nxt_dribb_state = smu_pkg::IDLE;
				end
			end
			default: nxt_dribb_state = smu_pkg::IDLE;
		endcase
	end

	// six-entry guard next state
	// an underflow is left to the dribbler, which already holds the pipe
	always_comb begin
		nxt_six_state = six_state;
		case (six_state)
			smu_pkg::SIX_IDLE: begin
				if (less_than_6 && !und_flw_d) begin
					nxt_six_state = smu_pkg::STALL_SIX;
				end
			end
			smu_pkg::STALL_SIX: begin
				if (!less_than_6) begin
					nxt_six_state = smu_pkg::SIX_IDLE;
				end
			end
			default: nxt_six_state = smu_pkg::SIX_IDLE;
		endcase
	end

endmodule

`default_nettype wire

/* dribbler/spill_fill_pipe.sv */
`default_nettype none
`timescale 1ns/100ps

// fill and spill request pipeline towards the data cache
// tracks loads and stores through the cache and write-back stages and makes
// the stack-bottom write enable, hold and select controls
module spill_fill_pipe (
	input  wire logic clk,
	input  wire logic arst_n,
	input  wire logic spill_d,
	input  wire logic fill_d,
	input  wire logic dcu_smu_stall,
	input  wire logic smu_data_vld,
	input  wire logic smu_st_c,
	input  wire logic iu_int,
	input  wire logic squash_fill,
	input  wire logic squash_hold,
	input  wire logic flush_pipe,
	input  wire logic dribble_stall,
	output logic      fill,
	output logic      spill,
	output logic      smu_ld,
	output logic      smu_st,
	output logic      smu_we,
	output logic      smu_sbase_we,
	output logic      sbase_hold,
	output logic      smu_prty,
	output logic      sbase_from_optop,
	output logic      nxt_sb_sel,
	output logic      scache_addr_sel
);

	// registered requests before direction masking
	logic fill_e;
	logic spill_e;

	// load and store flags in the cache and write-back stages
	logic load_c;
	logic load_w;
	logic store_c;
	logic store_w;

	// completion strobes from the DCU are realigned to the write-back stage
	logic smu_data_vld_w;
	logic smu_st_w;

	logic iu_int_c;
	logic keep_ld_st;
	logic stage_en;

	// a fresh request is dropped when the pipe is flushed, when the stack
	// bottom is being reloaded from optop, or on an interrupt
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			fill_e  <= 1'b0;
			spill_e <= 1'b0;
		end else begin
			fill_e  <= fill_d  & !(flush_pipe | squash_fill | iu_int);
			spill_e <= spill_d & !(flush_pipe | squash_fill | iu_int);
		end
	end

	// a spill while a load is still in flight would read the scache at the
	// fill address, and the same goes the other way round
	assign fill  = fill_e  & !store_c & !store_w;
	assign spill = spill_e & !load_c  & !load_w;

	assign smu_ld = fill;
	assign smu_st = spill;

	// the cache-stage stack bottom must still follow sbase in the cycle
	// after an interrupt, even under a DCU stall
	assign sbase_hold = dcu_smu_stall & !squash_hold & !iu_int_c;

	// flushes and interrupts clear the stage flags even through a hold
	assign keep_ld_st = !(flush_pipe | iu_int);
	assign stage_en   = !(sbase_hold & keep_ld_st);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			load_c  <= 1'b0;
			store_c <= 1'b0;
		end else if (stage_en) begin
			load_c  <= fill  & keep_ld_st;
			store_c <= spill & keep_ld_st;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			load_w         <= 1'b0;
			store_w        <= 1'b0;
			smu_data_vld_w <= 1'b0;
			smu_st_w       <= 1'b0;
			iu_int_c       <= 1'b0;
			smu_prty       <= 1'b0;
		end else begin
			load_w         <= load_c  & keep_ld_st;
			store_w        <= store_c & keep_ld_st;
			smu_data_vld_w <= smu_data_vld;
			smu_st_w       <= smu_st_c;
			iu_int_c       <= iu_int;
			// while the IU is held, the DCU serves SMU traffic first so a
			// pending IU load cannot deadlock against the stall
			smu_prty       <= dribble_stall;
		end
	end

	// fill data is written into the stack cache when the load completes
	assign smu_we = load_w & smu_data_vld_w;

	// the stack bottom moves when a load or store completes, and is reloaded
	// from optop on an underflow
	assign smu_sbase_we = (load_w & smu_data_vld_w) | (store_w & smu_st_w) | squash_fill;

	assign sbase_from_optop = squash_fill;

	// any request issued or in flight keeps the next stack bottom on the
	// pipelined value, so a repeated fill cannot reuse a stale address
	assign nxt_sb_sel = fill | spill | load_c | load_w | store_c | store_w;

	// during load write-back the scache is addressed from the write-back stage
	assign scache_addr_sel = load_w;

endmodule

`default_nettype wire

/* hdl/smu_ctl.sv */
`default_nettype none
`timescale 1ns/100ps

// stack management unit control
// keeps the stack cache between the low and high watermarks by dribbling
// fills and spills to the data cache, and holds the integer unit on overflow,
// underflow and when fewer than six entries are present
module smu_ctl (
	input  wire logic                             clk,
	input  wire logic                             arst_n,
	input  wire logic [smu_pkg::NUM_ENTRIES_W-1:0] num_entries,
	input  wire logic                             und_flw_bit,
	input  wire logic                             iu_psr_dre,
	input  wire logic                             iu_int,
	input  wire logic [smu_pkg::MARK_W-1:0]       low_mark,
	input  wire logic [smu_pkg::MARK_W-1:0]       high_mark,
	input  wire logic                             dcu_smu_stall,
	input  wire logic                             smu_data_vld,
	input  wire logic                             smu_st_c,
	input  wire logic                             zero_entries_fl,
	output logic                                  fill,
	output logic                                  spill,
	output logic                                  smu_ld,
	output logic                                  smu_st,
	output logic                                  smu_we,
	output logic                                  smu_sbase_we,
	output logic                                  dribble_stall,
	output logic                                  optop_en,
	output logic                                  sbase_hold,
	output logic                                  smu_prty,
	output logic                                  sbase_from_optop,
	output logic                                  nxt_sb_sel,
	output logic                                  scache_addr_sel
);

	// decoded level conditions, already qualified by the dribble enable
	logic spill_d;
	logic fill_d;
	logic ovr_flw_d;
	logic und_flw_d;
	logic less_than_6;

	// squash controls from the dribbler to the request pipeline
	logic squash_fill;
	logic squash_hold;
	logic flush_pipe;

	stack_level_cmp u_level (
		.num_entries (num_entries),
		.und_flw_bit (und_flw_bit),
		.iu_psr_dre  (iu_psr_dre),
		.low_mark    (low_mark),
		.high_mark   (high_mark),
		.spill_d     (spill_d),
		.fill_d      (fill_d),
		.ovr_flw_d   (ovr_flw_d),
		.und_flw_d   (und_flw_d),
		.less_than_6 (less_than_6)
	);

	// the dribbler looks at the issued spill to detect that the flush
	// address has reached the old optop
	dribble_fsm u_dribble (
		.clk             (clk),
		.arst_n          (arst_n),
		.spill_d         (spill_d),
		.ovr_flw_d       (ovr_flw_d),
		.und_flw_d       (und_flw_d),
		.less_than_6     (less_than_6),
		.spill           (spill),
		.zero_entries_fl (zero_entries_fl),
		.iu_int          (iu_int),
		.dribble_stall   (dribble_stall),
		.optop_en        (optop_en),
		.squash_fill     (squash_fill),
		.squash_hold     (squash_hold),
		.flush_pipe      (flush_pipe)
	);

	spill_fill_pipe u_pipe (
		.clk              (clk),
		.arst_n           (arst_n),
		.spill_d          (spill_d),
		.fill_d           (fill_d),
		.dcu_smu_stall    (dcu_smu_stall),
		.smu_data_vld     (smu_data_vld),
		.smu_st_c         (smu_st_c),
		.iu_int           (iu_int),
		.squash_fill      (squash_fill),
		.squash_hold      (squash_hold),
		.flush_pipe       (flush_pipe),
		.dribble_stall    (dribble_stall),
		.fill             (fill),
		.spill            (spill),
		.smu_ld           (smu_ld),
		.smu_st           (smu_st),
		.smu_we           (smu_we),
		.smu_sbase_we     (smu_sbase_we),
		.sbase_hold       (sbase_hold),
		.smu_prty         (smu_prty),
		.sbase_from_optop (sbase_from_optop),
		.nxt_sb_sel       (nxt_sb_sel),
		.scache_addr_sel  (scache_addr_sel)
	);

endmodule

`default_nettype wire

/* verification/smu_clk_gen.sv */
`default_nettype none
`timescale 1ns/100ps

// free running 8 ns clock for the stack management testbench
module smu_clk_gen (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	// half period of 4 ns
	always begin
		#4 clk = ~clk;
	end

endmodule

`default_nettype wire

/* verification/smu_tb.sv */
`default_nettype none
`timescale 1ns/100ps

// directed testbench for the stack management controller
// inputs change on the falling edge
// outputs are sampled at or shortly after it, never at the rising edge
module smu_tb;

	logic clk;
	logic arst_n;
	logic und_flw_bit;
	logic iu_psr_dre;
	logic iu_int;
	logic [smu_pkg::NUM_ENTRIES_W-1:0] num_entries;
	logic [smu_pkg::MARK_W-1:0] low_mark;
	logic [smu_pkg::MARK_W-1:0] high_mark;
	logic dcu_smu_stall;
	logic smu_data_vld;
	logic smu_st_c;
	logic zero_entries_fl;
	logic fill;
	logic spill;
	logic smu_ld;
	logic smu_st;
	logic smu_we;
	logic smu_sbase_we;
	logic dribble_stall;
	logic optop_en;
	logic sbase_hold;
	logic smu_prty;
	logic sbase_from_optop;
	logic nxt_sb_sel;
	logic scache_addr_sel;
	integer seed = 32'h6d47_055b;
	int   checks = 0;
	int   errors = 0;
	int   errors_seen = 0;

	smu_clk_gen u_clk (.clk(clk));

	smu_ctl u_dut (.*);

	// a condition that is not exactly high is a mismatch
	task automatic expect_high(input logic cond, input string msg);
		checks++;
		assert (cond === 1'b1) else begin
			$display("FAIL at %0t ns: %s", $time, msg);
			errors++;
		end
	endtask

	// picks a DUT output by name so one wait loop serves every signal
	function automatic logic probe(input string name);
		case (name)
			"fill":            probe = fill;
			"smu_st":          probe = smu_st;
			"scache_addr_sel": probe = scache_addr_sel;
			"nxt_sb_sel":      probe = nxt_sb_sel;
			"dribble_stall":   probe = dribble_stall;
			default:           probe = 1'bx;
		endcase
	endfunction

	// polls once per cycle and gives up after 40 cycles
	task automatic wait_level(input string name, input logic level);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			#1;
			n++;
		end while (probe(name) !== level && n < 40);
		if (probe(name) !== level) begin
			$display("timeout: %s did not reach %0b within 40 cycles", name, level);
			errors++;
		end
	endtask

	function automatic logic [smu_pkg::NUM_ENTRIES_W-1:0] pick(input int lo, input int span);
		int value;
		value = lo + ($unsigned($random(seed)) % span);
		pick = value[smu_pkg::NUM_ENTRIES_W-1:0];
	endfunction

	// a count between the marks stops all traffic, then the pipe has to drain
	task automatic go_midlevel();
		@(negedge clk);
		num_entries = 20;
		und_flw_bit = 1'b0;
		wait_level("nxt_sb_sel", 1'b0);
		wait_level("dribble_stall", 1'b0);
	endtask

	task automatic print_result(input string name);
		$display("test %-10s %s", name, (errors == errors_seen) ? "ok" : "failed");
		errors_seen = errors;
	endtask

	task automatic reset_and_disable();
		integer rnd;
		#1;
		expect_high(!(fill | spill | smu_ld | smu_st | smu_we | smu_sbase_we),
		            "requests after reset");
		expect_high(!(smu_prty | sbase_hold | sbase_from_optop), "controls after reset");
		// with the dribbler off no count may raise anything
		repeat (8) begin
			@(negedge clk);
			num_entries = pick(0, 1 << 20);
			rnd = $random(seed);
			und_flw_bit = rnd[0];
			#1;
			expect_high(!(fill | spill | dribble_stall), "activity with iu_psr_dre low");
		end
		@(negedge clk);
		num_entries = 20;
		und_flw_bit = 1'b0;
		iu_psr_dre = 1'b1;
		print_result("reset");
	endtask

	task automatic fill_and_load();
		@(negedge clk);
		num_entries = pick(6, 10);
		wait_level("fill", 1'b1);
		expect_high(smu_ld, "smu_ld low while fill is high");
		// the load has to reach write-back before the data can return
		wait_level("scache_addr_sel", 1'b1);
		@(negedge clk);
		smu_data_vld = 1'b1;
		@(negedge clk);
		smu_data_vld = 1'b0;
		#1;
		expect_high(smu_we && smu_sbase_we, "no stack write after smu_data_vld");
		go_midlevel();
		print_result("fill");
	endtask

	task automatic spill_and_store();
		int i;
		@(negedge clk);
		num_entries = pick(41, 19);
		wait_level("smu_st", 1'b1);
		// one more cycle puts the first store into the cache stage
		@(negedge clk);
		dcu_smu_stall = 1'b1;
		for (i = 0; i < 4; i++) begin
			@(negedge clk);
			#1;
			expect_high(sbase_hold && nxt_sb_sel, "sbase_hold low under DCU stall");
		end
		@(negedge clk);
		dcu_smu_stall = 1'b0;
		smu_st_c = 1'b1;
		@(negedge clk);
		smu_st_c = 1'b0;
		#1;
		expect_high(smu_sbase_we, "no stack bottom write after smu_st_c");
		go_midlevel();
		print_result("spill");
	endtask

	task automatic overflow_recovery();
		@(negedge clk);
		num_entries = pick(60, 1000);
		#1;
		expect_high(dribble_stall && !optop_en, "overflow not stalled in detect cycle");
		expect_high(!smu_prty, "smu_prty high before the stall was registered");
		// smu_prty is a registered copy of the stall
		@(negedge clk);
		expect_high(smu_prty, "smu_prty low after overflow");
		num_entries = 20;
		iu_int = 1'b1;
		@(negedge clk);
		iu_int = 1'b0;
		wait_level("dribble_stall", 1'b0);
		go_midlevel();
		print_result("overflow");
	endtask

	task automatic underflow_recovery();
		@(negedge clk);
		num_entries = pick(0, 1 << 20);
		und_flw_bit = 1'b1;
		#1;
		expect_high(dribble_stall && !sbase_from_optop, "underflow detect cycle wrong");
		@(negedge clk);
		#1;
		expect_high(sbase_from_optop && smu_sbase_we, "no stack bottom reload from optop");
		@(negedge clk);
		expect_high(!sbase_from_optop, "sbase_from_optop longer than one cycle");
		und_flw_bit = 1'b0;
		num_entries = 10;
		wait_level("dribble_stall", 1'b0);
		go_midlevel();
		print_result("underflow");
	endtask

	task automatic six_entry_guard();
		@(negedge clk);
		num_entries = pick(3, 3);
		repeat (6) begin
			#1;
			expect_high(dribble_stall, "stall low with fewer than six entries");
			@(negedge clk);
		end
		num_entries = pick(6, 10);
		wait_level("dribble_stall", 1'b0);
		go_midlevel();
		print_result("six_guard");
	endtask

	initial begin
		arst_n = 1'b0;
		num_entries = 20;
		und_flw_bit = 1'b0;
		iu_psr_dre = 1'b0;
		iu_int = 1'b0;
		zero_entries_fl = 1'b0;
		dcu_smu_stall = 1'b0;
		smu_data_vld = 1'b0;
		smu_st_c = 1'b0;
		low_mark = 6'd16;
		high_mark = 6'd40;
		repeat (16) @(negedge clk);
		arst_n = 1'b1;
		reset_and_disable();
		fill_and_load();
		spill_and_store();
		overflow_recovery();
		underflow_recovery();
		six_entry_guard();
		$display("checks run %0d, failures %0d", checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	// last resort if a test never returns
	initial begin
		#200us;
		$display("watchdog expired before all tests finished");
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
common/smu_pkg.sv
watermark/stack_level_cmp.sv
dribbler/dribble_fsm.sv
dribbler/spill_fill_pipe.sv
hdl/smu_ctl.sv
verification/smu_clk_gen.sv
verification/smu_tb.sv
